// ==== Makefile ====
# Verilator flow for the cluster finder

VERILATOR   ?= verilator
TOP         ?= cluster_finder_tb
FILELIST    ?= compile.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
LINT_FLAGS  ?= -Wall
BUILD_FLAGS ?= --binary --timing --assert
PASS_TEXT   ?= Regression passed
FAIL_TEXT   ?= Regression failed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+') include/cluster_defs.svh
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the run result comes from the log, so a crashed binary still reaches the search
sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ended without a result line"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+include
source/cluster_pkg.sv
source/truncate_clusters.sv
source/lowest_hit_encoder.sv
source/cluster_collector.sv
source/cluster_finder_top.sv
tb/cluster_finder_sva.sv
tb/cluster_finder_tb.sv

// ==== include/cluster_defs.svh ====
// bus width, segment count, address width, cluster limit and count width macros
`ifndef CLUSTER_DEFS_SVH
`define CLUSTER_DEFS_SVH

// number of one-bit hit flags latched per event
`define CF_NUM_HITS 64

// number of truncation segments
// the segment count has to divide the hit bus width evenly
`define CF_NUM_SEGS 4

// bits needed to address any single hit on the bus
`define CF_ADR_BITS 6

// clusters forwarded per event before the rest are dropped and flagged as overflow
`define CF_MAX_CLUSTERS 8

// width of the per-event cluster count
// it must be able to hold CF_MAX_CLUSTERS itself
`define CF_CNT_BITS 4

`endif

// ==== source/cluster_collector.sv ====
// per-event FSM that forwards, counts and limits clusters and reports the event result
`timescale 1ns/1ps
`default_nettype none

`include "cluster_defs.svh"

module cluster_collector
  import cluster_pkg::*;
(
  input  logic         clock,
  input  logic         rst,
  input  logic         hits_valid,
  input  logic         enc_valid,
  input  hit_adr_t     enc_adr,
  output logic         cluster_valid,
  output hit_adr_t     cluster_adr,
  output logic         event_done,
  output cluster_cnt_t cluster_count,
  output logic         overflow
);

  localparam cluster_cnt_t MAX_CNT = cluster_cnt_t'(`CF_MAX_CLUSTERS);

  collect_state_t state;

  // the strobe delayed by the encoder latency marks the first result of an event
  logic [1:0] strobe_dly;

  // clusters forwarded so far in this event
  cluster_cnt_t count;
  logic         at_limit;

  assign at_limit = (count == MAX_CNT);

  always_ff @(posedge clock) begin
    if (rst) begin
      strobe_dly <= '0;
    end else begin
      strobe_dly <= {strobe_dly[0], hits_valid};
    end
  end

  // ------------------------------
  // event FSM
  // ------------------------------

  always_ff @(posedge clock) begin
    if (rst) begin
      state         <= idle;
      count         <= '0;
      cluster_valid <= 1'b0;
      event_done    <= 1'b0;
      overflow      <= 1'b0;
    end else begin
      // all three output flags are single-cycle strobes
      cluster_valid <= 1'b0;
      event_done    <= 1'b0;
      overflow      <= 1'b0;
      if (hits_valid) begin
        // a new strobe restarts the event from any state
        state <= wait_pipe;
        count <= '0;
      end else begin
        case (state)
          idle: begin
            state <= idle;
          end
          wait_pipe: begin
            // leaves once the first image of the event reaches the encoder output
            if (strobe_dly[1]) begin
              state <= collect;
            end
          end
          collect: begin
            if (enc_valid && !at_limit) begin
              cluster_valid <= 1'b1;
              count         <= count + cluster_cnt_t'(1);
            end else begin
              // an empty image or the limit ends the event here
              // a hit still pending at the limit means clusters were dropped
              event_done <= 1'b1;
              overflow   <= enc_valid;
              state      <= report;
            end
          end
          report: begin
            state <= idle;
          end
          default: begin
            state <= idle;
          end
        endcase
      end
    end
  end

  // ------------------------------
  // payload
  // ------------------------------

  // address and count are only read alongside their strobes
  always_ff @(posedge clock) begin
    cluster_adr   <= enc_adr;
    cluster_count <= count;
  end

endmodule

`default_nettype wire

// ==== source/cluster_finder_top.sv ====
// top level joining the hit truncator, the lowest-hit encoder and the cluster collector
`timescale 1ns/1ps
`default_nettype none

`include "cluster_defs.svh"

module cluster_finder_top
  import cluster_pkg::*;
(
  input  logic                    clock,
  input  logic                    rst,
  input  logic [`CF_NUM_HITS-1:0] hits,
  input  logic                    hits_valid,
  output logic                    cluster_valid,
  output hit_adr_t                cluster_adr,
  output logic                    event_done,
  output cluster_cnt_t            cluster_count,
  output logic                    overflow
);

  // the truncated image loses its lowest hit every cycle
  logic [`CF_NUM_HITS-1:0] vpfs_image;

  // encoder result for the image two cycles back
  logic     enc_valid;
  hit_adr_t enc_adr;

  // ------------------------------
  // datapath
  // ------------------------------

  // the image equals hits right after the strobe edge
  truncate_clusters u_truncate (
    .clock       (clock),
    .rst         (rst),
    .latch_pulse (hits_valid),
    .vpfs_in     (hits),
    .vpfs_out    (vpfs_image)
  );

  // two cycles of fixed latency from image to address
  lowest_hit_encoder u_encoder (
    .clock     (clock),
    .rst       (rst),
    .vpfs      (vpfs_image),
    .enc_valid (enc_valid),
    .enc_adr   (enc_adr)
  );

  // ------------------------------
  // event control
  // ------------------------------

  // the collector adds one more cycle, so cluster 0 appears three edges after the strobe
  cluster_collector u_collector (
    .clock         (clock),
    .rst           (rst),
    .hits_valid    (hits_valid),
    .enc_valid     (enc_valid),
    .enc_adr       (enc_adr),
    .cluster_valid (cluster_valid),
    .cluster_adr   (cluster_adr),
    .event_done    (event_done),
    .cluster_count (cluster_count),
    .overflow      (overflow)
  );

endmodule

`default_nettype wire

// ==== source/cluster_pkg.sv ====
// cluster finder package with segment size, address, count, segment and collector state types
`default_nettype none

`include "cluster_defs.svh"

package cluster_pkg;

  // ------------------------------
  // derived sizes
  // ------------------------------

  // hit flags held by one truncation segment
  localparam int SEG_BITS = `CF_NUM_HITS / `CF_NUM_SEGS;

  // ------------------------------
  // types
  // ------------------------------

  // address of one hit flag on the bus
  typedef logic [`CF_ADR_BITS-1:0] hit_adr_t;

  // number of clusters reported for one event
  typedef logic [`CF_CNT_BITS-1:0] cluster_cnt_t;

  // one segment worth of hit flags
  // the truncator and the encoder both slice the bus into these
  typedef logic [SEG_BITS-1:0] seg_t;

  // collector FSM states
  // idle waits for a strobe, wait_pipe covers the encoder latency,
  // collect forwards addresses and report is the cycle that shows event_done
  typedef enum logic [1:0] {
    idle      = 2'd0,
    wait_pipe = 2'd1,
    collect   = 2'd2,
    report    = 2'd3
  } collect_state_t;

endpackage

`default_nettype wire

// ==== source/lowest_hit_encoder.sv ====
// two-stage pipelined priority encoder returning the address of the lowest set hit
`timescale 1ns/1ps
`default_nettype none

`include "cluster_defs.svh"

module lowest_hit_encoder
  import cluster_pkg::*;
(
  input  logic                    clock,
  input  logic                    rst,
  input  logic [`CF_NUM_HITS-1:0] vpfs,
  output logic                    enc_valid,
  output hit_adr_t                enc_adr
);

  // the truncator changes its image every cycle, so one image sits in stage 1
  // while the one before it is being resolved in stage 2
  //
  // an image present after edge j shows up on enc_valid and enc_adr after edge j+2

  localparam int NSEGS    = `CF_NUM_SEGS;
  localparam int OFF_BITS = $clog2(SEG_BITS);

  // ------------------------------
  // stage 1 per-segment search
  // ------------------------------

  seg_t [NSEGS-1:0] segs;

  // offset of the lowest set bit in each segment and whether it has any bit
  logic [NSEGS-1:0][OFF_BITS-1:0] seg_off_d;
  logic [NSEGS-1:0]               seg_any_d;

  // registered stage 1 results
  logic [NSEGS-1:0][OFF_BITS-1:0] seg_off_q;
  logic [NSEGS-1:0]               seg_any_q;

  // stage 2 combinational pick
  logic     sel_valid;
  hit_adr_t sel_adr;

  assign segs = vpfs;

  // scanning from the top down lets the lowest set bit overwrite the others
  // an empty segment gives offset zero, which the any flag masks later
  function automatic logic [OFF_BITS-1:0] lowest_offset(input seg_t word);
    logic [OFF_BITS-1:0] off;
    off = '0;
    for (int i = SEG_BITS - 1; i >= 0; i--) begin
      if (word[i]) begin
        off = OFF_BITS'(i);
      end
    end
    return off;
  endfunction

  always_comb begin
    for (int s = 0; s < NSEGS; s++) begin
      seg_any_d[s] = |segs[s];
      seg_off_d[s] = lowest_offset(segs[s]);
    end
  end

  // the offsets only matter where the any flag is set
  always_ff @(posedge clock) begin
    seg_off_q <= seg_off_d;
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      seg_any_q <= '0;
    end else begin
      seg_any_q <= seg_any_d;
    end
  end

  // ------------------------------
  // stage 2 segment select
  // ------------------------------

  // the lowest flagged segment wins, again by scanning from the top down
  always_comb begin
    sel_valid = 1'b0;
    sel_adr   = '0;
    for (int s = NSEGS - 1; s >= 0; s--) begin
      if (seg_any_q[s]) begin
        sel_valid = 1'b1;
        // segment base plus the offset found inside it
        sel_adr   = hit_adr_t'(s * SEG_BITS) + hit_adr_t'(seg_off_q[s]);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      enc_valid <= 1'b0;
    end else begin
      enc_valid <= sel_valid;
    end
  end

  // address is payload and is only read together with enc_valid
  always_ff @(posedge clock) begin
    enc_adr <= sel_adr;
  end

endmodule

`default_nettype wire

// ==== source/truncate_clusters.sv ====
// segmented hit register that loads on a strobe and clears the lowest set bit every cycle
`timescale 1ns/1ps
`default_nettype none

`include "cluster_defs.svh"

module truncate_clusters
  import cluster_pkg::*;
(
  input  logic                    clock,
  input  logic                    rst,
  input  logic                    latch_pulse,
  input  logic [`CF_NUM_HITS-1:0] vpfs_in,
  output logic [`CF_NUM_HITS-1:0] vpfs_out
);

  // the truncation works on the bits alone and never needs to know where the
  // lowest set bit sits, so the encoder can run pipelined beside it
  //
  // for a segment value a, the two's complement -a equals ~a+1 and keeps only
  // the lowest set bit of a together with the zeros below it
  // a & ~(~a+1) is therefore a with that lowest bit cleared
  //
  // each segment does this on its own short carry chain
  // a segment is held unchanged while any lower segment still has a bit,
  // so exactly one bit leaves the whole bus per cycle

  localparam int NSEGS = `CF_NUM_SEGS;

  // ------------------------------
  // segment views
  // ------------------------------

  // the packed segment arrays map directly onto the flat bus
  seg_t [NSEGS-1:0] seg_in;
  seg_t [NSEGS-1:0] seg_q;
  seg_t [NSEGS-1:0] seg_next;

  // a segment is active while it still holds at least one hit
  logic [NSEGS-1:0] seg_active;

  // a segment keeps its bits while some lower segment is active
  logic [NSEGS-1:0] seg_keep;

  assign seg_in = vpfs_in;

  always_comb begin
    for (int s = 0; s < NSEGS; s++) begin
      seg_active[s] = |seg_q[s];
    end
  end

  // the lowest segment never waits on anything
  assign seg_keep[0] = 1'b0;

  // a wide OR over all lower segments keeps this path shallow
  for (genvar s = 1; s < NSEGS; s++) begin : g_keep
    assign seg_keep[s] = |seg_active[s-1:0];
  end

  // ------------------------------
  // truncation
  // ------------------------------

  always_comb begin
    for (int s = 0; s < NSEGS; s++) begin
      // when kept, the OR mask is all ones and the segment passes through
      seg_next[s] = seg_q[s] & ({SEG_BITS{seg_keep[s]}} | ~(~seg_q[s] + seg_t'(1)));
    end
  end

  // a strobe always wins so a new event replaces whatever is left
  always_ff @(posedge clock) begin
    if (rst) begin
      seg_q <= '0;
    end else if (latch_pulse) begin
      seg_q <= seg_in;
    end else begin
      seg_q <= seg_next;
    end
  end

  assign vpfs_out = seg_q;

endmodule

`default_nettype wire

// ==== tb/cluster_finder_sva.sv ====
// concurrent output checks for the cluster finder top level and their bind
`timescale 1ns/1ps
`default_nettype none

module cluster_finder_sva
  import cluster_pkg::*;
(
  input logic     clock,
  input logic     rst,
  input logic     cluster_valid,
  input hit_adr_t cluster_adr,
  input logic     event_done,
  input logic     overflow
);

  // ------------------------------
  // output rules
  // ------------------------------

  // a reset edge leaves all three strobes low
  reset_quiet: assert property (@(posedge clock)
    rst |=> (!cluster_valid && !event_done && !overflow))
    else $error("output strobe high after a reset edge");

  // the report cycle never carries a cluster
  strobes_apart: assert property (@(posedge clock) disable iff (rst)
    !(cluster_valid && event_done))
    else $error("cluster_valid and event_done high together");

  // clusters of one event come back to back, lowest address first
  adr_rising: assert property (@(posedge clock) disable iff (rst)
    (cluster_valid && $past(cluster_valid)) |-> (cluster_adr > $past(cluster_adr)))
    else $error("cluster address did not increase within an event");

  // overflow is only meaningful in the report cycle
  overflow_with_done: assert property (@(posedge clock) disable iff (rst)
    overflow |-> event_done)
    else $error("overflow high without event_done");

endmodule

bind cluster_finder_top cluster_finder_sva u_sva (
  .clock         (clock),
  .rst           (rst),
  .cluster_valid (cluster_valid),
  .cluster_adr   (cluster_adr),
  .event_done    (event_done),
  .overflow      (overflow)
);

`default_nettype wire

// ==== tb/cluster_finder_tb.sv ====
// table-driven testbench for the cluster finder with a reference model, checks and a summary
`timescale 1ns/1ps
`default_nettype none

`include "cluster_defs.svh"

module cluster_finder_tb
  import cluster_pkg::*;
();

  // strobes must be at least this many cycles apart
  localparam int MIN_GAP    = `CF_MAX_CLUSTERS + 4;
  localparam int WAIT_LIMIT = 4 * `CF_MAX_CLUSTERS;
  localparam int N_RANDOM   = 12;

  logic                    clock;
  logic                    rst;
  logic [`CF_NUM_HITS-1:0] hits;
  logic                    hits_valid;
  logic                    cluster_valid;
  hit_adr_t                cluster_adr;
  logic                    event_done;
  cluster_cnt_t            cluster_count;
  logic                    overflow;

  // edge counter, read 1 ns after each rising edge
  int          cycle_cnt = 0;
  int          error_count;
  int          rows_ok;
  int          rows_bad;
  bit          timed_out;
  logic [31:0] lfsr_state;

  // stimulus table with the expected count and overflow of each row
  logic [`CF_NUM_HITS-1:0] row_hits [$];
  int                      row_gap [$];
  cluster_cnt_t            row_count [$];
  logic                    row_overflow [$];

  cluster_finder_top DUT (
    .clock         (clock),
    .rst           (rst),
    .hits          (hits),
    .hits_valid    (hits_valid),
    .cluster_valid (cluster_valid),
    .cluster_adr   (cluster_adr),
    .event_done    (event_done),
    .cluster_count (cluster_count),
    .overflow      (overflow)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ------------------------------
  // helpers
  // ------------------------------

  // one step of a right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hA300_0000;
    end
    return s >> 1;
  endfunction

  // every bit taken costs one LFSR step
  task automatic draw_bits(input int n, output logic [`CF_NUM_HITS-1:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[b]       = lfsr_state[0];
    end
  endtask

  function automatic logic [`CF_NUM_HITS-1:0] single_hit(input int b);
    logic [`CF_NUM_HITS-1:0] v;
    v    = '0;
    v[b] = 1'b1;
    return v;
  endfunction

  function automatic int hit_total(input logic [`CF_NUM_HITS-1:0] p);
    int n;
    n = 0;
    for (int b = 0; b < `CF_NUM_HITS; b++) begin
      if (p[b]) begin
        n++;
      end
    end
    return n;
  endfunction

  // count saturates at the cluster limit, and overflow marks any hit beyond it
  task automatic add_row(input logic [`CF_NUM_HITS-1:0] pattern, input int gap);
    int n;
    n = hit_total(pattern);
    row_hits.push_back(pattern);
    row_gap.push_back(gap);
    if (n > `CF_MAX_CLUSTERS) begin
      row_count.push_back(cluster_cnt_t'(`CF_MAX_CLUSTERS));
      row_overflow.push_back(1'b1);
    end else begin
      row_count.push_back(cluster_cnt_t'(n));
      row_overflow.push_back(1'b0);
    end
  endtask

  task automatic build_table();
    logic [`CF_NUM_HITS-1:0] a;
    logic [`CF_NUM_HITS-1:0] b;
    logic [`CF_NUM_HITS-1:0] c;
    logic [`CF_NUM_HITS-1:0] d;
    logic [`CF_NUM_HITS-1:0] g;
    add_row('0, MIN_GAP);
    // single hits on both sides of the segment boundaries
    add_row(single_hit(0), MIN_GAP);
    add_row(single_hit(SEG_BITS - 1), MIN_GAP);
    add_row(single_hit(SEG_BITS), MIN_GAP + 3);
    add_row(single_hit(2 * SEG_BITS - 1), MIN_GAP);
    add_row(single_hit(3 * SEG_BITS), MIN_GAP);
    add_row(single_hit(`CF_NUM_HITS - 1), MIN_GAP);
    // one hit in every segment
    add_row(64'h1000_0100_0010_0008, MIN_GAP);
    // hits only in the top segment, so all lower segments start empty
    add_row(64'h00F0_0000_0000_0000, MIN_GAP);
    // exactly the limit, then one over, then well over
    add_row(64'h8001_8001_8001_8001, MIN_GAP);
    add_row(64'h8001_8001_8001_8081, MIN_GAP);
    add_row(64'h0000_0000_0000_03FF, MIN_GAP + 5);
    add_row('1, MIN_GAP);
    add_row(64'h0000_0000_0000_0001, MIN_GAP);
    // random rows with falling hit density, mostly at the minimum spacing
    for (int r = 0; r < N_RANDOM; r++) begin
      draw_bits(`CF_NUM_HITS, a);
      draw_bits(`CF_NUM_HITS, b);
      draw_bits(2, g);
      case (r % 3)
        0: begin
          add_row(a & b, MIN_GAP + int'(g[1:0]));
        end
        1: begin
          draw_bits(`CF_NUM_HITS, c);
          add_row(a & b & c, MIN_GAP);
        end
        default: begin
          draw_bits(`CF_NUM_HITS, c);
          draw_bits(`CF_NUM_HITS, d);
          add_row(a & b & c & d, MIN_GAP);
        end
      endcase
    end
  endtask

  // inputs change and outputs are read 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge clock);
    #1;
  endtask

  // waits for the next cluster_valid or event_done
  task automatic wait_strobe(output bit seen);
    int waited;
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < WAIT_LIMIT) begin
      step_cycle();
      waited++;
      seen = cluster_valid || event_done;
    end
  endtask

  // ------------------------------
  // one event
  // ------------------------------

  task automatic run_row(input int r);
    hit_adr_t exp_adr [$];
    int       n_exp;
    int       e;
    int       k;
    int       i;
    int       b;
    int       extra;
    int       errs_before;
    bit       seen;
    bit       got_done;

    errs_before = error_count;
    got_done    = 1'b0;
    extra       = 0;
    // expected addresses come from a scan upward from bit 0
    for (b = 0; b < `CF_NUM_HITS; b++) begin
      if (row_hits[r][b] && exp_adr.size() < `CF_MAX_CLUSTERS) begin
        exp_adr.push_back(hit_adr_t'(b));
      end
    end
    n_exp = exp_adr.size();

    // the strobe is sampled at edge k
    e          = cycle_cnt;
    k          = e + 1;
    hits       = row_hits[r];
    hits_valid = 1'b1;
    step_cycle();
    hits_valid = 1'b0;

    for (i = 0; i < n_exp && !got_done && !timed_out; i++) begin
      wait_strobe(seen);
      assert (seen) else begin
        $display("row %0d: no output strobe within %0d cycles while waiting for cluster %0d",
                 r, WAIT_LIMIT, i);
        error_count++;
        timed_out = 1'b1;
      end
      if (seen) begin
        assert (cluster_valid) else begin
          $display("row %0d: event_done arrived after only %0d of %0d clusters", r, i, n_exp);
          error_count++;
        end
        got_done = event_done && !cluster_valid;
        if (cluster_valid) begin
          assert (cluster_adr == exp_adr[i]) else begin
            $display("FAIL cluster_adr expected %h got %h", exp_adr[i], cluster_adr);
            error_count++;
          end
          assert (cycle_cnt - k == 3 + i) else begin
            $display("row %0d: cluster %0d came %0d cycles after the strobe edge, not %0d",
                     r, i, cycle_cnt - k, 3 + i);
            error_count++;
          end
        end
      end
    end

    // anything other than event_done from here on is a surplus cluster
    while (!got_done && !timed_out && extra <= `CF_NUM_HITS) begin
      wait_strobe(seen);
      assert (seen) else begin
        $display("row %0d: event_done did not arrive within %0d cycles", r, WAIT_LIMIT);
        error_count++;
        timed_out = 1'b1;
      end
      if (seen) begin
        got_done = event_done;
        assert (!cluster_valid) else begin
          $display("row %0d: surplus cluster_valid with address %h", r, cluster_adr);
          error_count++;
          extra++;
        end
      end
    end
    assert (got_done || timed_out) else begin
      $display("row %0d: event_done never arrived among the surplus clusters", r);
      error_count++;
      timed_out = 1'b1;
    end

    if (got_done) begin
      assert (cluster_count == row_count[r]) else begin
        $display("FAIL cluster_count expected %h got %h", row_count[r], cluster_count);
        error_count++;
      end
      assert (overflow == row_overflow[r]) else begin
        $display("FAIL overflow expected %h got %h", row_overflow[r], overflow);
        error_count++;
      end
      assert (cycle_cnt - k == 3 + n_exp) else begin
        $display("row %0d: event_done came %0d cycles after the strobe edge, not %0d",
                 r, cycle_cnt - k, 3 + n_exp);
        error_count++;
      end
    end

    // hold the spacing to the next strobe
    // the outputs stay quiet from the report cycle until the next event starts
    while (!timed_out && cycle_cnt < e + row_gap[r]) begin
      step_cycle();
      assert (!cluster_valid && !event_done) else begin
        $display("row %0d: output strobe %0d cycles after the strobe edge, after event_done",
                 r, cycle_cnt - k);
        error_count++;
      end
    end

    if (error_count == errs_before) begin
      rows_ok++;
      $display("row %0d: hits %h, %0d clusters, overflow %0d, ok",
               r, row_hits[r], n_exp, row_overflow[r]);
    end else begin
      rows_bad++;
      $display("row %0d: hits %h, %0d errors", r, row_hits[r], error_count - errs_before);
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    clock       = 1'b0;
    rst         = 1'b1;
    hits        = '0;
    hits_valid  = 1'b0;
    error_count = 0;
    rows_ok     = 0;
    rows_bad    = 0;
    timed_out   = 1'b0;
    lfsr_state  = 32'he0ca43f5;
    build_table();
    // reset covers three rising edges
    repeat (3) step_cycle();
    rst = 1'b0;
    repeat (2) step_cycle();
    for (int r = 0; r < row_hits.size() && !timed_out; r++) begin
      run_row(r);
    end
    $display("rows %0d, ok %0d, with errors %0d, errors %0d",
             row_hits.size(), rows_ok, rows_bad, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
